// ==== compile.f ====
design/ds2_pkg.sv
design/ds2_link.sv
design/ds2_mode_sequencer.sv
design/ds2_pad_decoder.sv
design/ds2_controller.sv
verification/ds2_pad_model.sv
verification/tb_ds2_controller.sv

// ==== design/ds2_controller.sv ====
`timescale 1ns/1ps

module ds2_controller import ds2_pkg::*; (
    input  logic       clk_spi,
    input  logic       rst,
    input  logic       vsync,          // One frame per rising edge
    input  logic       analog,         // 1 analog, 0 digital
    input  logic       ds2_dat,
    input  logic       ds2_ack,
    output logic       ds2_att,
    output logic       ds2_clk,
    output logic       ds2_cmd,
    output logic       pad_ready,
    output logic       key_up,
    output logic       key_down,
    output logic       key_left,
    output logic       key_right,
    output logic       key_l1,
    output logic       key_l2,
    output logic       key_r1,
    output logic       key_r2,
    output logic       key_triangle,
    output logic       key_square,
    output logic       key_circle,
    output logic       key_cross,
    output logic       key_start,
    output logic       key_select,
    output logic       key_lstick,
    output logic       key_rstick,
    output logic [7:0] stick_lx,
    output logic [7:0] stick_ly,
    output logic [7:0] stick_rx,
    output logic [7:0] stick_ry
);

    ds2_cmd_e   frame_cmd;      // Held for the whole frame
    logic       cfg_enter;
    logic       mode;
    logic [7:0] rx_byte;
    logic [3:0] rx_index;
    logic       rx_valid;
    logic       frame_done;
    logic       frame_error;    // Abort pulse, ends the attention window

    ////////////////////////////////////////////////////////////////////////////
    // Frame engine
    ////////////////////////////////////////////////////////////////////////////
    ds2_link u_link (
        .clk_spi     (clk_spi),
        .rst         (rst),
        .vsync       (vsync),
        .ds2_dat     (ds2_dat),
        .ds2_ack     (ds2_ack),
        .frame_cmd   (frame_cmd),
        .cfg_enter   (cfg_enter),
        .mode        (mode),
        .ds2_att     (ds2_att),
        .ds2_clk     (ds2_clk),
        .ds2_cmd     (ds2_cmd),
        .rx_byte     (rx_byte),
        .rx_index    (rx_index),
        .rx_valid    (rx_valid),
        .frame_done  (frame_done),
        .frame_error (frame_error)
    );

    // Command choice per frame
    ds2_mode_sequencer u_sequencer (
        .clk_spi    (clk_spi),
        .rst        (rst),
        .analog     (analog),
        .frame_done (frame_done),
        .frame_cmd  (frame_cmd),
        .cfg_enter  (cfg_enter),
        .mode       (mode),
        .pad_ready  (pad_ready)
    );

    // Poll reply to keys and sticks
    ds2_pad_decoder u_decoder (
        .clk_spi      (clk_spi),
        .rst          (rst),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .rx_index     (rx_index),
        .frame_done   (frame_done),
        .frame_cmd    (frame_cmd),
        .pad_ready    (pad_ready),
        .key_up       (key_up),
        .key_down     (key_down),
        .key_left     (key_left),
        .key_right    (key_right),
        .key_l1       (key_l1),
        .key_l2       (key_l2),
        .key_r1       (key_r1),
        .key_r2       (key_r2),
        .key_triangle (key_triangle),
        .key_square   (key_square),
        .key_circle   (key_circle),
        .key_cross    (key_cross),
        .key_start    (key_start),
        .key_select   (key_select),
        .key_lstick   (key_lstick),
        .key_rstick   (key_rstick),
        .stick_lx     (stick_lx),
        .stick_ly     (stick_ly),
        .stick_rx     (stick_rx),
        .stick_ry     (stick_ry)
    );

endmodule

// ==== design/ds2_link.sv ====
`timescale 1ns/1ps

module ds2_link import ds2_pkg::*; (
    input  logic        clk_spi,
    input  logic        rst,
    input  logic        vsync,
    input  logic        ds2_dat,
    input  logic        ds2_ack,
    input  ds2_cmd_e    frame_cmd,
    input  logic        cfg_enter,
    input  logic        mode,
    output logic        ds2_att,
    output logic        ds2_clk,
    output logic        ds2_cmd,
    output logic [7:0]  rx_byte,
    output logic [3:0]  rx_index,
    output logic        rx_valid,
    output logic        frame_done,
    output logic        frame_error
);

    link_state_e state;
    link_state_e state_nxt;
    logic [4:0]  delta;        // Cycles spent in current state
    logic [2:0]  bit_cnt;
    logic [3:0]  byte_cnt;
    logic [7:0]  rx_shift;
    logic [7:0]  tx_byte;
    logic        vsync_d;
    logic        vsync_rise;

    assign vsync_rise = vsync & ~vsync_d;
    assign tx_byte    = ds2_tx_byte(frame_cmd, byte_cnt, cfg_enter, mode);

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            LNK_IDLE:  if (vsync_rise) state_nxt = LNK_ATT;  // Edges mid-frame ignored
            LNK_ATT:   if (delta == 5'(ATT_DELAY)) state_nxt = LNK_TX;
            LNK_TX:    state_nxt = LNK_RX;
            LNK_RX: begin
                if (bit_cnt == 3'(BYTE_BITS - 1))
                    state_nxt = LNK_EOB;
                else
                    state_nxt = LNK_TX;
            end
            LNK_EOB: begin
                // Last byte needs no ack
                if (byte_cnt == 4'(FRAME_BYTES - 1))
                    state_nxt = LNK_END;
                else
                    state_nxt = LNK_ACK_L;
            end
            LNK_ACK_L: begin
                if (!ds2_ack)
                    state_nxt = LNK_ACK_H;
                else if (delta == 5'(ACK_TIMEOUT))
                    state_nxt = LNK_ERR;                    // No pad or pad gave up
            end
            LNK_ACK_H: if (delta == 5'(ACK_COOLDOWN)) state_nxt = LNK_TX;
            LNK_END:   state_nxt = LNK_IDLE;
            LNK_ERR:   state_nxt = LNK_IDLE;
            default:   state_nxt = LNK_IDLE;
        endcase
    end

    always_ff @(posedge clk_spi or posedge rst) begin
        if (rst) begin
            state   <= LNK_IDLE;
            delta   <= 5'd0;
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= vsync;
            state   <= state_nxt;
            if (state_nxt != state)
                delta <= 5'd0;                              // Restart on every transition
            else
                delta <= delta + 5'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wire side and counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_spi or posedge rst) begin
        if (rst) begin
            ds2_att  <= 1'b1;
            ds2_clk  <= 1'b1;                               // Clock idles high
            ds2_cmd  <= 1'b1;
            bit_cnt  <= 3'd0;
            byte_cnt <= 4'd0;
        end else begin
            case (state)
                LNK_IDLE: begin
                    if (vsync_rise)
                        ds2_att <= 1'b0;                    // Select the pad
                end
                LNK_TX: begin
                    ds2_clk <= 1'b0;
                    ds2_cmd <= tx_byte[bit_cnt];            // LSB first
                end
                LNK_RX: begin
                    ds2_clk <= 1'b1;                        // Pad samples cmd here
                    bit_cnt <= bit_cnt + 3'd1;
                end
                LNK_EOB: begin
                    bit_cnt  <= 3'd0;
                    byte_cnt <= byte_cnt + 4'd1;
                end
                LNK_END, LNK_ERR: begin
                    ds2_att  <= 1'b1;                       // Release the pad
                    ds2_cmd  <= 1'b1;
                    bit_cnt  <= 3'd0;
                    byte_cnt <= 4'd0;
                end
                default: ;
            endcase
        end
    end

    // Receive shift, filled from the top so bit 0 lands last
    always_ff @(posedge clk_spi) begin
        if (state == LNK_RX)
            rx_shift <= {ds2_dat, rx_shift[7:1]};
    end

    assign rx_byte     = rx_shift;
    assign rx_index    = byte_cnt;
    assign rx_valid    = (state == LNK_EOB);
    assign frame_done  = (state == LNK_END);
    assign frame_error = (state == LNK_ERR);

    // Clock may only pulse inside an attention window
    assert property (@(posedge clk_spi) disable iff (rst) !ds2_clk |-> !ds2_att);

    assert property (@(posedge clk_spi) disable iff (rst) !(frame_done && frame_error));

endmodule

// ==== design/ds2_mode_sequencer.sv ====
`timescale 1ns/1ps

module ds2_mode_sequencer import ds2_pkg::*; (
    input  logic     clk_spi,
    input  logic     rst,
    input  logic     analog,
    input  logic     frame_done,
    output ds2_cmd_e frame_cmd,
    output logic     cfg_enter,
    output logic     mode,
    output logic     pad_ready
);

    seq_state_e state;
    seq_state_e step_nxt;
    logic [$clog2(CFG_REPEAT)-1:0] frame_cnt;   // Completed frames in this step
    logic       analog_d;
    logic       analog_chg;
    logic       chg_pend;                        // Mode change waiting for frame end
    logic       step_last;

    assign analog_chg = analog ^ analog_d;
    assign step_last  = (frame_cnt == ($clog2(CFG_REPEAT))'(CFG_REPEAT - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Step order and per-step command
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (state)
            SEQ_STARTUP:     step_nxt = SEQ_CFG_ENTER;
            SEQ_CFG_ENTER:   step_nxt = SEQ_SET_MODE;
            SEQ_SET_MODE:    step_nxt = SEQ_CFG_EXIT;
            SEQ_CFG_EXIT:    step_nxt = SEQ_POLL_SETTLE;
            SEQ_POLL_SETTLE: step_nxt = SEQ_POLLING;
            default:         step_nxt = SEQ_POLLING;     // Polling holds
        endcase
    end

    always_comb begin
        cfg_enter = 1'b0;
        case (state)
            SEQ_CFG_ENTER: begin
                frame_cmd = CMD_CONFIG;
                cfg_enter = 1'b1;                        // 43 .. 01
            end
            SEQ_SET_MODE:  frame_cmd = CMD_SET_MODE;
            SEQ_CFG_EXIT:  frame_cmd = CMD_CONFIG;       // 43 .. 00 + 5A pad
            default:       frame_cmd = CMD_POLL;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Step machine, advances only at frame boundaries
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_spi or posedge rst) begin
        if (rst) begin
            state     <= SEQ_STARTUP;
            frame_cnt <= '0;
            mode      <= 1'b0;
            analog_d  <= 1'b0;
            chg_pend  <= 1'b0;
            pad_ready <= 1'b0;
        end else begin
            analog_d <= analog;
            if (state == SEQ_POLLING) begin
                // Drop ready at once, switch commands only between frames
                pad_ready <= !(chg_pend || analog_chg);
                if (analog_chg)
                    chg_pend <= 1'b1;
                if (frame_done && (chg_pend || analog_chg)) begin
                    mode      <= analog;                 // Latest requested mode
                    chg_pend  <= 1'b0;
                    frame_cnt <= '0;
                    state     <= SEQ_CFG_ENTER;
                end
            end else begin
                pad_ready <= 1'b0;
                if (frame_done) begin
                    if (step_last) begin
                        frame_cnt <= '0;
                        state     <= step_nxt;
                        if (state == SEQ_STARTUP)
                            mode <= analog;              // Initial mode choice
                    end else begin
                        frame_cnt <= frame_cnt + ($clog2(CFG_REPEAT))'(1);
                    end
                end
            end
        end
    end

    // Ready only ever reported while plain polling runs
    assert property (@(posedge clk_spi) disable iff (rst) pad_ready |-> frame_cmd == CMD_POLL);

endmodule

// ==== design/ds2_pad_decoder.sv ====
`timescale 1ns/1ps

module ds2_pad_decoder import ds2_pkg::*; (
    input  logic       clk_spi,
    input  logic       rst,
    input  logic       rx_valid,
    input  logic [7:0] rx_byte,
    input  logic [3:0] rx_index,
    input  logic       frame_done,
    input  ds2_cmd_e   frame_cmd,
    input  logic       pad_ready,
    output logic       key_up,
    output logic       key_down,
    output logic       key_left,
    output logic       key_right,
    output logic       key_l1,
    output logic       key_l2,
    output logic       key_r1,
    output logic       key_r2,
    output logic       key_triangle,
    output logic       key_square,
    output logic       key_circle,
    output logic       key_cross,
    output logic       key_start,
    output logic       key_select,
    output logic       key_lstick,
    output logic       key_rstick,
    output logic [7:0] stick_lx,
    output logic [7:0] stick_ly,
    output logic [7:0] stick_rx,
    output logic [7:0] stick_ry
);

    logic [7:0] shadow [FIRST_DATA_BYTE:FRAME_BYTES-1];   // Bytes of the running frame
    logic [7:0] vis    [FIRST_DATA_BYTE:FRAME_BYTES-1];   // Last good poll reply
    logic       data_byte;

    assign data_byte = (rx_index >= 4'(FIRST_DATA_BYTE)) && (rx_index < 4'(FRAME_BYTES));

    always_ff @(posedge clk_spi) begin
        if (rx_valid && data_byte)
            shadow[rx_index] <= rx_byte;
    end

    // Aborted frames never reach frame_done, so outputs hold
    always_ff @(posedge clk_spi or posedge rst) begin
        if (rst) begin
            for (int i = FIRST_DATA_BYTE; i < FRAME_BYTES; i++)
                vis[i] <= 8'hFF;                              // Released, sticks read 00
        end else if (frame_done && frame_cmd == CMD_POLL) begin
            for (int i = FIRST_DATA_BYTE; i < FRAME_BYTES; i++)
                vis[i] <= shadow[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Active-low pad bits to active-high keys
    ////////////////////////////////////////////////////////////////////////////
    assign key_select   = ~vis[FIRST_DATA_BYTE][0] & pad_ready;
    assign key_rstick   = ~vis[FIRST_DATA_BYTE][1];
    assign key_lstick   = ~vis[FIRST_DATA_BYTE][2];
    assign key_start    = ~vis[FIRST_DATA_BYTE][3] & pad_ready;
    assign key_up       = ~vis[FIRST_DATA_BYTE][4];
    assign key_right    = ~vis[FIRST_DATA_BYTE][5];
    assign key_down     = ~vis[FIRST_DATA_BYTE][6];
    assign key_left     = ~vis[FIRST_DATA_BYTE][7];
    assign key_l2       = ~vis[FIRST_DATA_BYTE+1][0];
    assign key_r2       = ~vis[FIRST_DATA_BYTE+1][1];
    assign key_l1       = ~vis[FIRST_DATA_BYTE+1][2];
    assign key_r1       = ~vis[FIRST_DATA_BYTE+1][3];
    assign key_triangle = ~vis[FIRST_DATA_BYTE+1][4] & pad_ready;  // Face keys gated
    assign key_circle   = ~vis[FIRST_DATA_BYTE+1][5] & pad_ready;
    assign key_cross    = ~vis[FIRST_DATA_BYTE+1][6] & pad_ready;
    assign key_square   = ~vis[FIRST_DATA_BYTE+1][7] & pad_ready;

    // Stick order on the wire is right pair then left pair
    assign stick_rx = ~vis[FIRST_DATA_BYTE+2];
    assign stick_ry = ~vis[FIRST_DATA_BYTE+3];
    assign stick_lx = ~vis[FIRST_DATA_BYTE+4];
    assign stick_ly = ~vis[FIRST_DATA_BYTE+5];

endmodule

// ==== design/ds2_pkg.sv ====
package ds2_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Protocol timing and framing
    ////////////////////////////////////////////////////////////////////////////
    localparam int unsigned FRAME_BYTES     = 9;   // Every transfer is nine bytes
    localparam int unsigned BYTE_BITS       = 8;
    localparam int unsigned ATT_DELAY       = 4;   // Attention low before first bit
    localparam int unsigned ACK_TIMEOUT     = 31;  // Longest wait for pad ack
    localparam int unsigned ACK_COOLDOWN    = 8;   // Gap after ack before next byte
    localparam int unsigned CFG_REPEAT      = 16;  // Completed frames per config step
    localparam int unsigned FIRST_DATA_BYTE = 3;   // First button byte in a poll reply

    // Frame engine states
    typedef enum logic [3:0] {
        LNK_IDLE,
        LNK_ATT,     // Attention asserted, settle delay
        LNK_TX,      // Clock low, drive cmd bit
        LNK_RX,      // Clock high, sample dat bit
        LNK_EOB,     // Byte complete
        LNK_ACK_L,   // Waiting for pad ack
        LNK_ACK_H,   // Cool-down after ack
        LNK_END,
        LNK_ERR
    } link_state_e;

    // Configuration steps
    typedef enum logic [2:0] {
        SEQ_STARTUP,
        SEQ_CFG_ENTER,
        SEQ_SET_MODE,
        SEQ_CFG_EXIT,
        SEQ_POLL_SETTLE,
        SEQ_POLLING
    } seq_state_e;

    // On-wire command opcodes, byte 1 of the frame
    typedef enum logic [7:0] {
        CMD_POLL     = 8'h42,
        CMD_CONFIG   = 8'h43,
        CMD_SET_MODE = 8'h44
    } ds2_cmd_e;

    // Transmit byte for a frame position
    function automatic logic [7:0] ds2_tx_byte(input ds2_cmd_e   cmd,
                                               input logic [3:0] idx,
                                               input logic       cfg_enter,
                                               input logic       mode);
        logic [7:0] b;
        b = 8'h00;                                       // Unlisted bytes are zero
        case (idx)
            4'd0: b = 8'h01;                             // Start byte
            4'd1: b = cmd;
            4'd3: begin
                if (cmd == CMD_CONFIG)
                    b = {7'd0, cfg_enter};               // 01 enter, 00 exit
                else if (cmd == CMD_SET_MODE)
                    b = {7'd0, mode};                    // 01 analog, 00 digital
            end
            4'd4, 4'd5, 4'd6, 4'd7, 4'd8: begin
                if (cmd == CMD_SET_MODE && idx == 4'd4)
                    b = 8'h03;                           // Lock mode key
                else if (cmd == CMD_CONFIG && !cfg_enter)
                    b = 8'h5A;                           // Exit config padding
            end
            default: b = 8'h00;
        endcase
        return b;
    endfunction

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ds2_controller -f compile.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run.sh: test passed"
else
    echo "run.sh: test failed"
    exit 1
fi

// ==== verification/ds2_pad_model.sv ====
`timescale 1ns/1ps

module ds2_pad_model (
    input  logic        clk_spi,
    input  logic        ds2_att,
    input  logic        ds2_clk,
    input  logic        ds2_cmd,
    input  logic        withhold_ack,   // Stay silent after each byte
    input  logic [47:0] reply,          // Bytes 3 to 8, byte 3 in the low bits
    output logic        ds2_dat,
    output logic        ds2_ack,
    output logic [7:0]  rec_b1,
    output logic [7:0]  rec_b3,
    output logic [7:0]  rec_b4,
    output logic [15:0] rec_count       // Completed frames seen so far
);

    logic [7:0] rx_bytes [0:8];
    logic [7:0] rx_shift;
    int         bit_idx;
    int         byte_idx;
    int         ack_left;
    logic       ack_req;

    // Reply bit for a frame position, header bytes are fixed
    function automatic logic reply_bit(int byte_n, int bit_n);
        logic [47:0] data;
        logic [7:0]  b;
        case (byte_n)
            0:       b = 8'hFF;
            1:       b = 8'h73;                     // Analog pad id
            2:       b = 8'h5A;
            default: begin
                data = reply >> (8 * (byte_n - 3));
                b    = data[7:0];
            end
        endcase
        b = b >> bit_n;                             // LSB first
        return b[0];
    endfunction

    initial begin
        ds2_dat   = 1'b1;
        ds2_ack   = 1'b1;
        rec_b1    = 8'h00;
        rec_b3    = 8'h00;
        rec_b4    = 8'h00;
        rec_count = 16'd0;
        rx_shift  = 8'h00;
        bit_idx   = 0;
        byte_idx  = 0;
        ack_left  = 0;
        ack_req   = 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Serial side
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge ds2_att) begin
        bit_idx  = 0;                               // New frame
        byte_idx = 0;
    end

    always @(negedge ds2_clk) begin
        if (!ds2_att && byte_idx < 9)
            ds2_dat = reply_bit(byte_idx, bit_idx);
    end

    always @(posedge ds2_clk) begin
        if (!ds2_att && byte_idx < 9) begin
            rx_shift = {ds2_cmd, rx_shift[7:1]};    // Bit 0 arrives first
            if (bit_idx == 7) begin
                rx_bytes[byte_idx] = rx_shift;
                if (byte_idx < 8 && !withhold_ack)
                    ack_req = 1'b1;                 // Last byte is never acked
                byte_idx = byte_idx + 1;
                bit_idx  = 0;
            end else begin
                bit_idx = bit_idx + 1;
            end
        end
    end

    // Aborted frames end early and are not recorded
    always @(posedge ds2_att) begin
        if (byte_idx == 9) begin
            rec_b1    = rx_bytes[1];
            rec_b3    = rx_bytes[3];
            rec_b4    = rx_bytes[4];
            rec_count = rec_count + 16'd1;
        end
    end

    // Ack pulse, two clk_spi cycles low
    always @(posedge clk_spi) begin
        #1;
        if (ack_req) begin
            ack_req  = 1'b0;
            ack_left = 2;
        end
        if (ack_left > 0) begin
            ds2_ack  = 1'b0;
            ack_left = ack_left - 1;
        end else begin
            ds2_ack = 1'b1;
        end
    end

endmodule

// ==== verification/tb_ds2_controller.sv ====
`timescale 1ns/1ps

module tb_ds2_controller
    import ds2_pkg::*;
();

    localparam int VSYNC_PERIOD = 400;
    localparam int WAIT_LIMIT   = 1000;    // Cycles, covers one vsync period

    logic        clk_spi;
    logic        rst;
    logic        vsync;
    logic        analog;
    logic        ds2_dat;
    logic        ds2_ack;
    logic        ds2_att;
    logic        ds2_clk;
    logic        ds2_cmd;
    logic        pad_ready;
    logic        key_up, key_down, key_left, key_right;
    logic        key_l1, key_l2, key_r1, key_r2;
    logic        key_triangle, key_square, key_circle, key_cross;
    logic        key_start, key_select, key_lstick, key_rstick;
    logic [7:0]  stick_lx, stick_ly, stick_rx, stick_ry;
    logic        withhold;
    logic [47:0] reply;                    // Next reply bytes 3 to 8
    logic [47:0] shown;                    // Reply the outputs should show
    logic [7:0]  rec_b1, rec_b3, rec_b4;
    logic [15:0] rec_count;
    logic [15:0] frames_before;            // Completed frames before the abort
    int          vsync_cnt;

    ds2_controller u_ds2_controller (.*);

    ds2_pad_model u_pad (
        .clk_spi      (clk_spi),
        .ds2_att      (ds2_att),
        .ds2_clk      (ds2_clk),
        .ds2_cmd      (ds2_cmd),
        .withhold_ack (withhold),
        .reply        (reply),
        .ds2_dat      (ds2_dat),
        .ds2_ack      (ds2_ack),
        .rec_b1       (rec_b1),
        .rec_b3       (rec_b3),
        .rec_b4       (rec_b4),
        .rec_count    (rec_count)
    );

    initial begin
        clk_spi = 1'b0;
        forever #2 clk_spi = ~clk_spi;
    end

    // One vsync pulse per period
    initial begin
        vsync     = 1'b0;
        vsync_cnt = 0;
        forever begin
            @(posedge clk_spi);
            #1;
            vsync_cnt = (vsync_cnt == VSYNC_PERIOD - 1) ? 0 : vsync_cnt + 1;
            vsync     = (vsync_cnt == VSYNC_PERIOD - 1);
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [7:0] got, logic [7:0] exp);
        assert (got == exp)
            else abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        assert (got == exp)
            else abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic new_reply();
        reply = {16'($urandom()), $urandom()};
    endtask

    // Pad bits are active low, select/start/face keys need pad_ready
    task automatic check_outputs(logic [47:0] r, logic rdy);
        logic [7:0] got3;
        logic [7:0] got4;
        got3 = {key_left, key_down, key_right, key_up,
                key_start, key_lstick, key_rstick, key_select};
        got4 = {key_square, key_cross, key_circle, key_triangle,
                key_r1, key_l1, key_r2, key_l2};
        check_value("key_left..key_select", got3, ~r[7:0] & {4'hF, rdy, 2'b11, rdy});
        check_value("key_square..key_l2", got4, ~r[15:8] & {{4{rdy}}, 4'hF});
        check_value("stick_rx", stick_rx, ~r[23:16]);
        check_value("stick_ry", stick_ry, ~r[31:24]);
        check_value("stick_lx", stick_lx, ~r[39:32]);
        check_value("stick_ly", stick_ly, ~r[47:40]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Waits, each bounded
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_frame();
        logic [15:0] seen;
        seen = rec_count;
        for (int i = 0; i < WAIT_LIMIT && rec_count == seen; i++) begin
            @(posedge clk_spi);
            #1;
        end
        if (rec_count == seen)
            abort_run("Timeout waiting for a completed frame");
        assert (rec_b1 == 8'h42 || rec_b1 == 8'h43 || rec_b1 == 8'h44)
            else abort_run($sformatf("FAIL rec_b1 0x%h is not a legal command", rec_b1));
    endtask

    task automatic wait_att(logic level);
        for (int i = 0; i < WAIT_LIMIT && ds2_att != level; i++) begin
            @(posedge clk_spi);
            #1;
        end
        if (ds2_att != level)
            abort_run($sformatf("Timeout waiting for ds2_att to reach %0d", level));
    endtask

    task automatic wait_ready(logic level);
        for (int i = 0; i < WAIT_LIMIT && pad_ready != level; i++) begin
            @(posedge clk_spi);
            #1;
        end
        if (pad_ready != level)
            abort_run($sformatf("Timeout waiting for pad_ready to reach %0d", level));
    endtask

    // One configuration step, pad_ready stays low throughout
    task automatic expect_commands(logic [7:0] cmd, logic [7:0] b3, logic [7:0] b4, int n);
        repeat (n) begin
            wait_frame();
            check_value("rec_b1", rec_b1, cmd);
            check_value("rec_b3", rec_b3, b3);
            check_value("rec_b4", rec_b4, b4);
            check_bit("pad_ready", pad_ready, 1'b0);
        end
    endtask

    task automatic poll_and_check(int n);
        repeat (n) begin
            wait_frame();
            check_value("rec_b1", rec_b1, 8'h42);
            @(posedge clk_spi);                    // Decoder updates after frame end
            #1;
            check_bit("pad_ready", pad_ready, 1'b1);
            check_outputs(reply, 1'b1);
            shown = reply;
            new_reply();
        end
    endtask

    // Wire format
    assert property (@(posedge clk_spi) disable iff (rst)
        (ds2_clk && !ds2_att) |-> $stable(ds2_cmd))
        else abort_run("ds2_cmd changed while ds2_clk was high");

    assert property (@(posedge clk_spi) disable iff (rst)
        (ds2_clk != $past(ds2_clk)) |-> !ds2_att)
        else abort_run("ds2_clk toggled while ds2_att was high");

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'ha687));
        rst      = 1'b1;
        analog   = 1'b1;
        withhold = 1'b0;
        shown    = '1;
        new_reply();
        repeat (8) @(posedge clk_spi);
        #1;
        rst = 1'b0;
        check_bit("ds2_att", ds2_att, 1'b1);
        check_bit("ds2_clk", ds2_clk, 1'b1);
        check_bit("ds2_cmd", ds2_cmd, 1'b1);
        check_bit("pad_ready", pad_ready, 1'b0);
        check_outputs(48'hFFFF_FFFF_FFFF, 1'b0);   // All released, sticks 00

        expect_commands(8'h42, 8'h00, 8'h00, CFG_REPEAT);
        expect_commands(8'h43, 8'h01, 8'h00, CFG_REPEAT);
        expect_commands(8'h44, 8'h01, 8'h03, CFG_REPEAT);
        expect_commands(8'h43, 8'h00, 8'h5A, CFG_REPEAT);
        expect_commands(8'h42, 8'h00, 8'h00, CFG_REPEAT);
        wait_ready(1'b1);
        poll_and_check(4);

        // Missing ack, frame aborts and outputs hold
        withhold      = 1'b1;
        frames_before = rec_count;
        wait_att(1'b0);
        wait_att(1'b1);
        @(posedge clk_spi);
        #1;
        assert (rec_count == frames_before && u_pad.byte_idx < 9)
            else abort_run("Aborted frame was reported as complete");
        check_outputs(shown, 1'b1);
        withhold = 1'b0;
        poll_and_check(2);

        // Mode change restarts config
        analog = 1'b0;
        wait_ready(1'b0);
        check_outputs(shown, 1'b0);
        expect_commands(8'h42, 8'h00, 8'h00, 1);   // Frame already in flight
        expect_commands(8'h43, 8'h01, 8'h00, CFG_REPEAT);
        expect_commands(8'h44, 8'h00, 8'h03, CFG_REPEAT);
        expect_commands(8'h43, 8'h00, 8'h5A, CFG_REPEAT);
        expect_commands(8'h42, 8'h00, 8'h00, CFG_REPEAT);
        wait_ready(1'b1);
        poll_and_check(3);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
